//--- rtl/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN   = 32;   // data and address width
    localparam int REG_AW = 5;    // register index
    localparam int EXP_W  = 7;    // one bit per exception cause

    // cause bit positions inside exp_t
    localparam int EXP_ALE  = 5;  // misaligned address
    localparam int EXP_ADEM = 6;  // address past the end of data RAM

    typedef logic [EXP_W-1:0] exp_t;

    // encoding matches the execute stage: 0 byte, 1 half, 2 word
    typedef enum logic [1:0] {
        MW_BYTE = 2'd0,
        MW_HALF = 2'd1,
        MW_WORD = 2'd2
    } mem_width_e;

    // address stage -> response stage, 50 bits
    typedef struct packed {
        logic [REG_AW-1:0] rd;     // zero for stores
        mem_width_e        width;
        logic              sign;   // sign-extend loaded value
        logic              store;
        logic [1:0]        ofs;    // byte offset inside the word
        exp_t              exp;    // incoming causes ORed with new ones
        logic [XLEN-1:0]   badv;   // computed address, qualified later
    } addr_stage_t;

    // writeback record, 76 bits
    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        exp_t              exp;
        logic [XLEN-1:0]   badv;
    } wb_t;

endpackage

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int DCACHE_WORDS = 256;  // data RAM depth
    localparam int DCACHE_AW    = 8;    // word index width
    localparam int DCACHE_OFS_W = 2;    // byte offset bits below the index
    localparam int DCACHE_NB    = 4;    // bytes per word

    // first byte address outside the RAM
    localparam int DCACHE_LIMIT = DCACHE_WORDS * DCACHE_NB;

    typedef logic [DCACHE_NB-1:0] byte_en_t;

    // base lane patterns, shifted up by the byte offset
    localparam byte_en_t BE_BYTE = 4'b0001;
    localparam byte_en_t BE_HALF = 4'b0011;
    localparam byte_en_t BE_WORD = 4'b1111;

    // write 1, read 0, as on the cache port of the old mem0
    typedef enum logic {
        DC_READ  = 1'b0,
        DC_WRITE = 1'b1
    } dcache_op_e;

endpackage

//--- rtl/dcache_req_if.sv
`timescale 1ns/1ps

// one request per access, no ready: the RAM always takes it
interface dcache_req_if import dcache_pkg::*, lsu_pkg::*; ();

    logic                 valid;    // single-cycle strobe
    dcache_op_e           op;
    logic [DCACHE_AW-1:0] index;    // addr[9:2]
    byte_en_t             byte_en;  // lanes written on a store
    logic [XLEN-1:0]      wdata;    // store data already in its lanes

    // address stage drives everything
    modport src (
        output valid,
        output op,
        output index,
        output byte_en,
        output wdata
    );

    // data RAM only listens
    modport dst (
        input valid,
        input op,
        input index,
        input byte_en,
        input wdata
    );

endinterface

//--- rtl/pipe_reg.sv
`timescale 1ns/1ps

// valid-tagged stage register, one per payload type
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    // valid bit is the only control state
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload holds its last value across bubbles
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

//--- rtl/mem_addr_stage.sv
`timescale 1ns/1ps

// address generation and cache request forming, purely combinational
module mem_addr_stage import lsu_pkg::*, dcache_pkg::*; (
    input  logic              op_valid,
    input  logic [REG_AW-1:0] op_rd,
    input  logic              op_store,
    input  mem_width_e        op_width,
    input  logic              op_sign,
    input  logic [XLEN-1:0]   op_base,
    input  logic [XLEN-1:0]   op_imm,
    input  logic [XLEN-1:0]   op_wdata,
    input  exp_t              op_exp,
    dcache_req_if.src         req,
    output addr_stage_t       pay
);

    logic [XLEN-1:0] addr;
    logic [1:0]      ofs;
    logic            ale;      // misaligned half or word
    logic            adem;     // beyond the RAM
    exp_t            exp_all;
    byte_en_t        be_base;  // lane pattern before the offset shift
    logic [XLEN-1:0] wdata_rep;

    assign addr = op_base + op_imm;
    assign ofs  = addr[DCACHE_OFS_W-1:0];

    always_comb begin
        case (op_width)
            MW_BYTE: ale = 1'b0;
            MW_HALF: ale = ofs[0];
            default: ale = |ofs;     // word, and the unused code
        endcase
    end

    assign adem = (addr >= XLEN'(DCACHE_LIMIT));

    // new causes join whatever execute already flagged
    always_comb begin
        exp_all           = op_exp;
        exp_all[EXP_ALE]  = op_exp[EXP_ALE] | ale;
        exp_all[EXP_ADEM] = op_exp[EXP_ADEM] | adem;
    end

    // write_type of the old design, plus the offset shift
    always_comb begin
        case (op_width)
            MW_BYTE: begin
                be_base   = BE_BYTE;
                wdata_rep = {4{op_wdata[7:0]}};   // every lane gets the byte
            end
            MW_HALF: begin
                be_base   = BE_HALF;
                wdata_rep = {2{op_wdata[15:0]}};
            end
            default: begin
                be_base   = BE_WORD;
                wdata_rep = op_wdata;
            end
        endcase
    end

    // any cause at all suppresses the access
    assign req.valid   = op_valid && (exp_all == '0);
    assign req.op      = op_store ? DC_WRITE : DC_READ;
    assign req.index   = addr[DCACHE_AW+DCACHE_OFS_W-1:DCACHE_OFS_W];
    assign req.byte_en = be_base << ofs;
    assign req.wdata   = wdata_rep;

    assign pay.rd    = op_store ? '0 : op_rd;   // stores write no register
    assign pay.width = op_width;
    assign pay.sign  = op_sign;
    assign pay.store = op_store;
    assign pay.ofs   = ofs;
    assign pay.exp   = exp_all;
    assign pay.badv  = addr;

endmodule

//--- rtl/dcache_ram.sv
`timescale 1ns/1ps

// byte-writable data RAM, read data registered for the next cycle
module dcache_ram import dcache_pkg::*, lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    dcache_req_if.dst       req,
    output logic [XLEN-1:0] rdata
);

    logic [XLEN-1:0] mem [DCACHE_WORDS];
    logic            wr_en;
    logic            rd_en;

    assign wr_en = req.valid && (req.op == DC_WRITE);
    assign rd_en = req.valid && (req.op == DC_READ);

    // start from all zeros, same as the model
    initial begin
        for (int i = 0; i < DCACHE_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // only the enabled lanes change
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < DCACHE_NB; b++) begin
                if (req.byte_en[b]) begin
                    mem[req.index][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // whole word out, lane pick happens in the response stage
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= mem[req.index];
        end
    end

endmodule

//--- rtl/mem_resp_stage.sv
`timescale 1ns/1ps

// merges RAM data with the access bits and forms the writeback record
module mem_resp_stage import lsu_pkg::*; (
    input  logic            pay_valid,
    input  addr_stage_t     pay,
    input  logic [XLEN-1:0] rdata,
    output logic            wb_valid,
    output wb_t             wb
);

    logic [7:0]      bsel;       // addressed byte
    logic [15:0]     hsel;       // addressed half
    logic [XLEN-1:0] ext;        // extended load value
    logic            fault;      // any cause set
    logic            addr_fault; // cause tied to the address

    // offset picks the lane, aligned accesses only get here with data
    always_comb begin
        case (pay.ofs)
            2'd0:    bsel = rdata[7:0];
            2'd1:    bsel = rdata[15:8];
            2'd2:    bsel = rdata[23:16];
            default: bsel = rdata[31:24];
        endcase
    end

    assign hsel = pay.ofs[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (pay.width)
            MW_BYTE: begin
                if (pay.sign) begin
                    ext = {{(XLEN-8){bsel[7]}}, bsel};
                end else begin
                    ext = {{(XLEN-8){1'b0}}, bsel};
                end
            end
            MW_HALF: begin
                if (pay.sign) begin
                    ext = {{(XLEN-16){hsel[15]}}, hsel};
                end else begin
                    ext = {{(XLEN-16){1'b0}}, hsel};
                end
            end
            default: ext = rdata;   // word passes whole
        endcase
    end

    assign fault      = |pay.exp;
    assign addr_fault = pay.exp[EXP_ALE] | pay.exp[EXP_ADEM];

    assign wb_valid = pay_valid;

    // a faulting access writes nothing back
    assign wb.rd   = fault ? '0 : pay.rd;
    assign wb.data = (pay.store || fault) ? '0 : ext;
    assign wb.exp  = pay.exp;
    assign wb.badv = addr_fault ? pay.badv : '0;   // only address causes report it

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ps

// load-store pipe: address stage, data RAM, response stage, 2-cycle latency
module lsu_top import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid,
    input  logic [REG_AW-1:0] op_rd,
    input  logic              op_store,
    input  mem_width_e        op_width,
    input  logic              op_sign,
    input  logic [XLEN-1:0]   op_base,
    input  logic [XLEN-1:0]   op_imm,
    input  logic [XLEN-1:0]   op_wdata,
    input  exp_t              op_exp,
    output logic              wb_valid,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]   wb_data,
    output exp_t              wb_exp,
    output logic [XLEN-1:0]   wb_badv
);

    dcache_req_if dreq ();

    addr_stage_t     addr_pay;   // address stage output, cycle k
    logic            mid_valid;
    addr_stage_t     mid_pay;    // registered payload, cycle k+1
    logic [XLEN-1:0] rdata;
    logic            resp_valid;
    wb_t             resp_wb;
    wb_t             wb_out;

    mem_addr_stage u_addr (
        .op_valid (op_valid),
        .op_rd    (op_rd),
        .op_store (op_store),
        .op_width (op_width),
        .op_sign  (op_sign),
        .op_base  (op_base),
        .op_imm   (op_imm),
        .op_wdata (op_wdata),
        .op_exp   (op_exp),
        .req      (dreq.src),
        .pay      (addr_pay)
    );

    dcache_ram u_ram (
        .clk   (clk),
        .rst   (rst),
        .req   (dreq.dst),
        .rdata (rdata)       // lines up with mid_pay
    );

    pipe_reg #(.T(addr_stage_t)) u_addr_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (op_valid),
        .in_data   (addr_pay),
        .out_valid (mid_valid),
        .out_data  (mid_pay)
    );

    mem_resp_stage u_resp (
        .pay_valid (mid_valid),
        .pay       (mid_pay),
        .rdata     (rdata),
        .wb_valid  (resp_valid),
        .wb        (resp_wb)
    );

    pipe_reg #(.T(wb_t)) u_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (resp_valid),
        .in_data   (resp_wb),
        .out_valid (wb_valid),
        .out_data  (wb_out)
    );

    // record fields onto the flat ports
    assign wb_rd   = wb_out.rd;
    assign wb_data = wb_out.data;
    assign wb_exp  = wb_out.exp;
    assign wb_badv = wb_out.badv;

endmodule

//--- dv/lsu_asserts.sv
`timescale 1ns/1ps

// protocol checks on the load-store pipe, bound into lsu_top
module lsu_asserts import lsu_pkg::*, dcache_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            op_valid,
    input mem_width_e      op_width,
    input logic [XLEN-1:0] op_base,
    input logic [XLEN-1:0] op_imm,
    input exp_t            op_exp,
    input logic            req_valid,
    input byte_en_t        req_be,
    input logic            wb_valid
);

    logic [XLEN-1:0] addr;       // access address seen at the issue ports
    logic            misalign;   // half on an odd byte, word off a 4-byte boundary
    logic            out_range;  // at or past the end of the RAM

    assign addr      = op_base + op_imm;
    assign misalign  = (op_width == MW_HALF && addr[0])
                    || (op_width == MW_WORD && addr[1:0] != 2'b00);
    assign out_range = (addr >= XLEN'(DCACHE_LIMIT));

    // a flagged access never reaches the RAM
    no_req_on_exception: assert property (
        @(posedge clk) disable iff (rst)
        (op_exp != '0 || misalign || out_range) |-> !req_valid
    ) else $error("cache request for a faulting access at %h", addr);

    // byte, half or word lanes only
    legal_byte_en: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> (req_be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0011, 4'b1100, 4'b1111})
    ) else $error("illegal byte enable pattern %b", req_be);

    // fixed latency, one record per issue
    wb_two_cycles: assert property (
        @(posedge clk) disable iff (rst) wb_valid == $past(op_valid, 2)
    ) else $error("wb_valid does not follow op_valid by two cycles");

    quiet_in_reset: assert property (
        @(posedge clk) rst |=> !wb_valid
    ) else $error("wb_valid high during reset");

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op_width  (op_width),
    .op_base   (op_base),
    .op_imm    (op_imm),
    .op_exp    (op_exp),
    .req_valid (dreq.valid),
    .req_be    (dreq.byte_en),
    .wb_valid  (wb_valid)
);

//--- dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int CLK_NS    = 4;
    localparam int RAM_BYTES = 1024;   // first address past the data RAM
    localparam int N1_WORDS  = 16;
    localparam int N2_RAND   = 40;
    localparam int N3_ROUNDS = 6;      // 4 accesses each
    localparam int N4_RANGE  = 12;
    localparam int N4_PASS   = 6;      // store plus load each
    localparam int N5_OPS    = 400;
    localparam int N_TOTAL   = 2*N1_WORDS + N2_RAND + 3 + 4*N3_ROUNDS + N4_RANGE
                               + 2*N4_PASS + N5_OPS;
    localparam int WD_NS     = (N_TOTAL + 20) * CLK_NS * 2;

    logic              clk;
    logic              rst;
    logic              op_valid;
    logic [REG_AW-1:0] op_rd;
    logic              op_store;
    mem_width_e        op_width;
    logic              op_sign;
    logic [XLEN-1:0]   op_base;
    logic [XLEN-1:0]   op_imm;
    logic [XLEN-1:0]   op_wdata;
    exp_t              op_exp;
    logic              wb_valid;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;
    exp_t              wb_exp;
    logic [XLEN-1:0]   wb_badv;

    logic [31:0] seed = 32'd94920;
    logic [7:0]  mem_model [RAM_BYTES];   // byte-addressed copy of the RAM
    wb_t         exp_q [$];               // records in issue order
    int          n_checks = 0;
    int          n_errors = 0;
    int          base_checks = 0;         // counts at the start of the current test
    int          base_errors = 0;

    lsu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 15);   // fold the better high bits down
    endfunction

    function automatic logic [31:0] rand_below(input logic [31:0] n);
        return next_rand() % n;
    endfunction

    function automatic mem_width_e rand_width();
        case (rand_below(3))
            32'd0:   return MW_BYTE;
            32'd1:   return MW_HALF;
            default: return MW_WORD;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] align_addr(input logic [XLEN-1:0] a, input mem_width_e w);
        case (w)
            MW_BYTE: return a;
            MW_HALF: return a & ~32'd1;
            default: return a & ~32'd3;
        endcase
    endfunction

    // expected record of one access, memory updated in issue order
    function automatic wb_t model_access(input logic store, input mem_width_e width,
                                         input logic sign, input logic [REG_AW-1:0] rd,
                                         input logic [XLEN-1:0] base, input logic [XLEN-1:0] imm,
                                         input logic [XLEN-1:0] wdata, input exp_t exp_in);
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] lane;
        logic [9:0]      ba;
        int              nb;
        wb_t             r;
        addr = base + imm;
        nb   = (width == MW_BYTE) ? 1 : (width == MW_HALF) ? 2 : 4;
        r.exp = exp_in;
        if ((width == MW_HALF && addr[0]) || (width == MW_WORD && addr[1:0] != 2'b00))
            r.exp[EXP_ALE] = 1'b1;
        if (addr >= RAM_BYTES)
            r.exp[EXP_ADEM] = 1'b1;
        val = '0;
        if (r.exp == '0) begin   // only clean accesses touch memory
            for (int i = 0; i < nb; i++) begin
                ba = addr[9:0] + 10'(i);
                if (store) begin
                    lane = wdata >> (8*i);   // low bytes of wdata, little endian
                    mem_model[ba] = lane[7:0];
                end else begin
                    val = val | ({24'h0, mem_model[ba]} << (8*i));
                end
            end
        end
        if (sign && width == MW_BYTE) val = {{24{val[7]}}, val[7:0]};
        if (sign && width == MW_HALF) val = {{16{val[15]}}, val[15:0]};
        r.rd   = (store || r.exp != '0) ? '0 : rd;
        r.data = (store || r.exp != '0) ? '0 : val;
        r.badv = (r.exp[EXP_ALE] || r.exp[EXP_ADEM]) ? addr : '0;
        return r;
    endfunction

    task automatic check_wb(input wb_t got, input wb_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            if (got.rd !== want.rd)
                $display("Mismatch at %0t: rd got %0d expected %0d", $time, got.rd, want.rd);
            if (got.data !== want.data)
                $display("Mismatch at %0t: data got %h expected %h", $time, got.data, want.data);
            if (got.exp !== want.exp)
                $display("Mismatch at %0t: exp got %b expected %b", $time, got.exp, want.exp);
            if (got.badv !== want.badv)
                $display("Mismatch at %0t: badv got %h expected %h", $time, got.badv, want.badv);
        end
    endtask

    task automatic check_count(input int outstanding);
        n_checks++;
        if (outstanding != 0) begin
            n_errors++;
            $display("Mismatch at %0t: %0d records outstanding, expected 0", $time, outstanding);
        end
    endtask

    // drive one access on the falling edge
    task automatic issue(input logic store, input mem_width_e width, input logic sign,
                         input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] wdata, input exp_t exp_in);
        logic [XLEN-1:0] imm;
        imm = rand_below(64) - 32'd32;   // small signed offset
        @(negedge clk);
        op_valid = 1'b1;
        op_rd    = rd;
        op_store = store;
        op_width = width;
        op_sign  = sign;
        op_base  = addr - imm;
        op_imm   = imm;
        op_wdata = wdata;
        op_exp   = exp_in;
        exp_q.push_back(model_access(store, width, sign, rd, addr - imm, imm, wdata, exp_in));
    endtask

    task automatic idle();
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    // wait for the pipe to empty, bounded, then report the test
    task automatic finish_test(input string name);
        idle();
        for (int i = 0; i < 10 && exp_q.size() != 0; i++) @(negedge clk);
        check_count(exp_q.size());
        $display("%-26s %0d checks, %0d errors", name, n_checks - base_checks,
                 n_errors - base_errors);
        base_checks = n_checks;
        base_errors = n_errors;
    endtask

    // each writeback pops the oldest expected record
    always @(negedge clk) begin
        wb_t got;
        if (!rst && wb_valid) begin
            got.rd   = wb_rd;
            got.data = wb_data;
            got.exp  = wb_exp;
            got.badv = wb_badv;
            if (exp_q.size() == 0) begin
                $display("unexpected writeback at %0t with no access outstanding", $time);
                n_errors++;
            end else begin
                check_wb(got, exp_q.pop_front());
            end
        end
    end

    task automatic test_word_round_trip();
        logic [XLEN-1:0] addrs [N1_WORDS];
        for (int i = 0; i < N1_WORDS; i++) begin
            addrs[i] = align_addr(rand_below(RAM_BYTES), MW_WORD);
            issue(1'b1, MW_WORD, 1'b0, REG_AW'(rand_below(32)), addrs[i], next_rand(), '0);
        end
        for (int i = 0; i < N1_WORDS; i++)
            issue(1'b0, MW_WORD, 1'b0, REG_AW'(rand_below(32)), addrs[i], '0, '0);
        finish_test("word round trip");
    endtask

    task automatic test_sub_word();
        logic [XLEN-1:0] a;
        mem_width_e      w;
        issue(1'b1, MW_BYTE, 1'b0, 5'd0, 32'h41, 32'h0000_00a5, '0);   // bit 7 set
        issue(1'b0, MW_BYTE, 1'b1, 5'd3, 32'h41, '0, '0);
        issue(1'b0, MW_BYTE, 1'b0, 5'd4, 32'h41, '0, '0);
        for (int i = 0; i < N2_RAND; i++) begin
            w = (rand_below(2) == 0) ? MW_BYTE : MW_HALF;
            a = align_addr(rand_below(64), w);   // narrow window, lanes overlap
            issue(1'(rand_below(2)), w, 1'(rand_below(2)), REG_AW'(rand_below(32)), a,
                  next_rand(), '0);
        end
        finish_test("sub-word access");
    endtask

    task automatic test_alignment();
        logic [XLEN-1:0] a;
        for (int i = 0; i < N3_ROUNDS; i++) begin
            a = align_addr(rand_below(RAM_BYTES), MW_WORD);
            issue(1'b1, MW_WORD, 1'b0, 5'd0, a, next_rand(), '0);
            issue(1'b1, (i % 2 == 1) ? MW_HALF : MW_WORD, 1'b0, 5'd0,
                  (i % 2 == 1) ? a + 32'd1 : a + 32'd2, next_rand(), '0);
            issue(1'b0, MW_HALF, 1'b1, 5'd7, a + 32'd3, '0, '0);
            issue(1'b0, MW_WORD, 1'b0, 5'd9, a, '0, '0);   // shows the word untouched
        end
        finish_test("alignment exceptions");
    endtask

    task automatic test_range_pass();
        logic [XLEN-1:0] a;
        mem_width_e      w;
        for (int i = 0; i < N4_RANGE; i++) begin
            w = rand_width();
            a = align_addr(32'd1024 + rand_below(4096), w);
            issue(1'(rand_below(2)), w, 1'b0, REG_AW'(rand_below(32)), a, next_rand(), '0);
        end
        for (int i = 0; i < N4_PASS; i++) begin
            a = align_addr(rand_below(RAM_BYTES), MW_WORD);
            issue(1'b1, MW_WORD, 1'b0, 5'd0, a, next_rand(), 7'(32'd1 + rand_below(127)));
            issue(1'b0, MW_WORD, 1'b0, 5'd2, a, '0, '0);
        end
        finish_test("range and pass-through");
    endtask

    task automatic test_mixed_traffic();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] last_a;
        logic            st;
        logic            prev_st;
        mem_width_e      w;
        exp_t            e;
        last_a  = '0;
        prev_st = 1'b0;
        for (int i = 0; i < N5_OPS; i++) begin
            if (rand_below(8) == 0) idle();   // occasional bubble
            w  = rand_width();
            st = 1'(rand_below(2));
            e  = '0;
            if (prev_st && rand_below(3) == 0) begin
                st = 1'b0;   // load right behind a store, same word
                w  = MW_WORD;
                a  = align_addr(last_a, MW_WORD);
            end else begin
                a = rand_below(128);
                if (rand_below(10) != 0) a = align_addr(a, w);
                if (rand_below(16) == 0) a = a + 32'd1024;
                if (rand_below(16) == 0) e = 7'(rand_below(128));
            end
            issue(st, w, 1'(rand_below(2)), REG_AW'(rand_below(32)), a, next_rand(), e);
            prev_st = st;
            last_a  = a;
        end
        finish_test("back-to-back mixed");
    endtask

    initial begin
        rst       = 1'b1;
        op_valid  = 1'b0;
        op_rd     = '0;
        op_store  = 1'b0;
        op_width  = MW_BYTE;
        op_sign   = 1'b0;
        op_base   = '0;
        op_imm    = '0;
        op_wdata  = '0;
        op_exp    = '0;
        mem_model = '{default: 8'h00};   // RAM starts cleared
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_word_round_trip();
        test_sub_word();
        test_alignment();
        test_range_pass();
        test_mixed_traffic();
        $display("all tests: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // bound from the number of issued accesses
    initial begin
        #(WD_NS);
        $display("timeout: run did not finish within %0d ns", WD_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- lsu_pipe.f
rtl/lsu_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_req_if.sv
rtl/pipe_reg.sv
rtl/mem_addr_stage.sv
rtl/dcache_ram.sv
rtl/mem_resp_stage.sv
rtl/lsu_top.sv
dv/lsu_asserts.sv
dv/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the load-store pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module lsu_tb -Mdir obj_dir -o lsu_sim \
    -f lsu_pipe.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only on an exact pass line
if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
